//--- verilog/fp_simd_pkg.sv
/*
 * Shared definitions for the SIMD non-computational FP slice.
 * Holds the float formats, the supported operations, the IEEE status
 * flags and the helper functions that give each format's field widths.
 * Modules pull this in with a wildcard import in their header.
 */
package fp_simd_pkg;

  // --------------------
  // Formats
  // --------------------
  localparam int unsigned NUM_FP_FORMATS = 3;
  localparam int unsigned LANE_BITS      = 8;  // Narrowest format, one lane slot

  typedef enum logic [1:0] {
    FP32 = 2'd0,
    FP16 = 2'd1,
    FP8  = 2'd2  // 5-bit exponent, 2-bit mantissa
  } fp_format_e;

  typedef enum logic [2:0] {
    SGNJ  = 3'd0,
    SGNJN = 3'd1,
    SGNJX = 3'd2,
    MIN   = 3'd3,
    MAX   = 3'd4
  } operation_e;

  // IEEE exception flags, only NV is raised by this slice
  typedef struct packed {
    logic NV;  // Invalid
    logic DZ;  // Divide by zero
    logic OF;  // Overflow
    logic UF;  // Underflow
    logic NX;  // Inexact
  } status_t;

  // --------------------
  // Format helpers
  // --------------------
  function automatic int unsigned fp_width(fp_format_e fmt);
    case (fmt)
      FP16:    return 16;
      FP8:     return 8;
      default: return 32;
    endcase
  endfunction

  function automatic int unsigned exp_bits(fp_format_e fmt);
    case (fmt)
      FP16:    return 5;
      FP8:     return 5;
      default: return 8;
    endcase
  endfunction

  function automatic int unsigned man_bits(fp_format_e fmt);
    case (fmt)
      FP16:    return 10;
      FP8:     return 2;
      default: return 23;
    endcase
  endfunction

endpackage

//--- verilog/pipe_stage.sv
`timescale 1ns/1ps
/*
 * Elastic register stage with a valid/ready handshake.
 * Accepts an item when valid_i and ready_o are both high and shows it
 * one cycle later. flush_i drops the held item. The payload type is a
 * parameter, so the same stage carries lane data and op info alike.
 */
module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,
  // Upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // Downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // Pass on when downstream takes the item or when the stage is empty
  assign ready_o = ready_i | ~valid_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload loads only on an accepted item
  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

  // A stalled item must not change under the consumer
  stall_stable_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i || flush_i)
    (valid_o && !ready_i) |=> $stable(data_o)
  );

endmodule

//--- verilog/noncomp_lane.sv
`timescale 1ns/1ps
/*
 * One SIMD lane of the non-computational unit, purely combinational.
 * Does sign injection and MIN/MAX on the low bits of a 32-bit slice for
 * each format that can start at this lane's position. Bits above the
 * active format come back as ones.
 */
module noncomp_lane import fp_simd_pkg::*; #(
  parameter int unsigned LaneIdx = 0,
  parameter int unsigned Width   = 32
) (
  input  logic [31:0] op_a_i,
  input  logic [31:0] op_b_i,
  input  fp_format_e  fmt_i,
  input  operation_e  op_i,
  output logic [31:0] result_o,
  output status_t     status_o
);

  logic [NUM_FP_FORMATS-1:0][31:0] fmt_result;
  status_t [NUM_FP_FORMATS-1:0]    fmt_status;

  for (genvar f = 0; f < NUM_FP_FORMATS; f++) begin : gen_fmt
    localparam int unsigned FW = fp_width(fp_format_e'(f));
    localparam int unsigned EB = exp_bits(fp_format_e'(f));
    localparam int unsigned MB = man_bits(fp_format_e'(f));

    // Only build a format if one of its elements lands on this lane
    if ((LaneIdx + 1) * FW <= Width) begin : gen_active
      logic          sign_a, sign_b;
      logic [EB-1:0] exp_a, exp_b;
      logic [MB-1:0] man_a, man_b;
      logic          nan_a, nan_b, snan_a, snan_b;
      logic          a_below_b;
      logic [31:0]   res;
      status_t       st;

      assign {sign_a, exp_a, man_a} = op_a_i[FW-1:0];
      assign {sign_b, exp_b, man_b} = op_b_i[FW-1:0];

      assign nan_a  = (&exp_a) & (|man_a);
      assign nan_b  = (&exp_b) & (|man_b);
      assign snan_a = nan_a & ~man_a[MB-1];  // Quiet bit clear
      assign snan_b = nan_b & ~man_b[MB-1];

      // Sign-magnitude order, -0 sits below +0
      always_comb begin : order
        if (sign_a != sign_b) begin
          a_below_b = sign_a;
        end else if (sign_a) begin
          a_below_b = op_a_i[FW-2:0] > op_b_i[FW-2:0];
        end else begin
          a_below_b = op_a_i[FW-2:0] < op_b_i[FW-2:0];
        end
      end

      always_comb begin : compute
        res         = '1;               // NaN-box above the format
        res[FW-1:0] = op_a_i[FW-1:0];
        st          = '0;
        case (op_i)
          SGNJ:  res[FW-1] = sign_b;
          SGNJN: res[FW-1] = ~sign_b;
          SGNJX: res[FW-1] = sign_a ^ sign_b;
          MIN, MAX: begin
            st.NV = snan_a | snan_b;
            if (nan_a && nan_b) begin
              res[FW-1:0] = {1'b0, {EB{1'b1}}, 1'b1, {(MB-1){1'b0}}};  // Canonical NaN
            end else if (nan_a) begin
              res[FW-1:0] = op_b_i[FW-1:0];
            end else if (!nan_b && (a_below_b == (op_i == MAX))) begin
              res[FW-1:0] = op_b_i[FW-1:0];
            end
          end
          default: res[FW-1:0] = op_a_i[FW-1:0];
        endcase
      end

      assign fmt_result[f] = res;
      assign fmt_status[f] = st;
    end else begin : gen_inactive
      assign fmt_result[f] = '1;
      assign fmt_status[f] = '0;
    end
  end

  always_comb begin : select_fmt
    result_o = '1;
    status_o = '0;
    if (fmt_i < NUM_FP_FORMATS) begin
      result_o = fmt_result[fmt_i];
      status_o = fmt_status[fmt_i];
    end
  end

endmodule

//--- verilog/lane_datapath.sv
`timescale 1ns/1ps
/*
 * Lane datapath of the slice. Slices both operands per lane for the
 * current format, runs one noncomp_lane per lane and carries every lane
 * result and status through NumPipeRegs elastic stages.
 * Its handshake chain sets the slice's in_ready_o and out_valid_o.
 */
module lane_datapath import fp_simd_pkg::*; #(
  parameter int unsigned  Width       = 32,
  parameter int unsigned  NumPipeRegs = 1,
  localparam int unsigned NUM_LANES   = Width / LANE_BITS
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       flush_i,
  input  logic                       in_valid_i,
  output logic                       in_ready_o,
  input  logic [Width-1:0]           operand_a_i,
  input  logic [Width-1:0]           operand_b_i,
  input  fp_format_e                 fmt_i,
  input  operation_e                 op_i,
  output logic                       out_valid_o,
  input  logic                       out_ready_i,
  output logic                       busy_o,
  output logic [NUM_LANES-1:0][31:0] lane_results_o,
  output status_t [NUM_LANES-1:0]    lane_status_o
);

  typedef struct packed {
    logic [NUM_LANES-1:0][31:0] results;
    status_t [NUM_LANES-1:0]    status;
  } lane_data_t;

  logic [NUM_LANES-1:0][31:0] lane_res;
  status_t [NUM_LANES-1:0]    lane_st;

  // --------------------
  // Lanes
  // --------------------
  for (genvar lane = 0; lane < NUM_LANES; lane++) begin : gen_lanes
    logic [31:0] local_a, local_b;

    assign local_a = 32'(operand_a_i >> (lane * fp_width(fmt_i)));  // Element for this lane
    assign local_b = 32'(operand_b_i >> (lane * fp_width(fmt_i)));

    noncomp_lane #(
      .LaneIdx ( lane  ),
      .Width   ( Width )
    ) u_lane (
      .op_a_i   ( local_a        ),
      .op_b_i   ( local_b        ),
      .fmt_i    ( fmt_i          ),
      .op_i     ( op_i           ),
      .result_o ( lane_res[lane] ),
      .status_o ( lane_st[lane]  )
    );
  end

  // --------------------
  // Pipeline
  // --------------------
  lane_data_t [0:NumPipeRegs] stage_data;
  logic       [0:NumPipeRegs] stage_valid;
  logic       [0:NumPipeRegs] stage_ready;

  assign stage_data[0]  = '{results: lane_res, status: lane_st};
  assign stage_valid[0] = in_valid_i;

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stages
    pipe_stage #(
      .payload_t ( lane_data_t )
    ) u_stage (
      .clk_i   ( clk_i            ),
      .rst_n_i ( rst_n_i          ),
      .flush_i ( flush_i          ),
      .valid_i ( stage_valid[i]   ),
      .ready_o ( stage_ready[i]   ),
      .data_i  ( stage_data[i]    ),
      .valid_o ( stage_valid[i+1] ),
      .ready_i ( stage_ready[i+1] ),
      .data_o  ( stage_data[i+1]  )
    );
  end

  assign stage_ready[NumPipeRegs] = out_ready_i;
  assign in_ready_o               = stage_ready[0];
  assign out_valid_o              = stage_valid[NumPipeRegs];
  assign lane_results_o           = stage_data[NumPipeRegs].results;
  assign lane_status_o            = stage_data[NumPipeRegs].status;

  if (NumPipeRegs > 0) begin : gen_busy
    assign busy_o = |stage_valid[1:NumPipeRegs];  // Items held in registers
  end else begin : gen_no_busy
    assign busy_o = 1'b0;
  end

endmodule

//--- verilog/op_info_pipe.sv
`timescale 1ns/1ps
/*
 * Operation info pipeline, running beside the lane datapath.
 * Works out which lanes contribute status for the incoming item and
 * carries that set, the tag, the format and the vectorial flag through
 * the same number of elastic stages, so both pipelines stay in lockstep.
 */
module op_info_pipe import fp_simd_pkg::*; #(
  parameter int unsigned  Width       = 32,
  parameter int unsigned  NumPipeRegs = 1,
  parameter type          TagType     = logic [7:0],
  localparam int unsigned NUM_LANES   = Width / LANE_BITS
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 flush_i,
  input  logic                 in_valid_i,
  input  logic                 out_ready_i,
  input  fp_format_e           fmt_i,
  input  logic                 vectorial_op_i,
  input  logic [NUM_LANES-1:0] simd_mask_i,
  input  TagType               tag_i,
  output logic                 busy_o,
  output fp_format_e           fmt_o,
  output logic                 vectorial_o,
  output logic [NUM_LANES-1:0] lane_active_o,
  output TagType               tag_o
);

  typedef struct packed {
    TagType               tag;
    fp_format_e           fmt;
    logic                 vectorial;
    logic [NUM_LANES-1:0] active;
  } info_t;

  logic [NUM_LANES-1:0] lane_active;

  // Lane counts if it is in use, fits the format and is not masked
  always_comb begin : decode_lanes
    for (int l = 0; l < NUM_LANES; l++) begin
      lane_active[l] = ((l == 0) | vectorial_op_i)
                     & (l < Width / fp_width(fmt_i))
                     & simd_mask_i[l];
    end
  end

  info_t [0:NumPipeRegs] stage_data;
  logic  [0:NumPipeRegs] stage_valid;
  logic  [0:NumPipeRegs] stage_ready;

  assign stage_data[0]  = '{tag: tag_i, fmt: fmt_i, vectorial: vectorial_op_i,
                            active: lane_active};
  assign stage_valid[0] = in_valid_i;

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stages
    pipe_stage #(
      .payload_t ( info_t )
    ) u_stage (
      .clk_i   ( clk_i            ),
      .rst_n_i ( rst_n_i          ),
      .flush_i ( flush_i          ),
      .valid_i ( stage_valid[i]   ),
      .ready_o ( stage_ready[i]   ),
      .data_i  ( stage_data[i]    ),
      .valid_o ( stage_valid[i+1] ),
      .ready_i ( stage_ready[i+1] ),
      .data_o  ( stage_data[i+1]  )
    );
  end

  assign stage_ready[NumPipeRegs] = out_ready_i;
  assign tag_o         = stage_data[NumPipeRegs].tag;
  assign fmt_o         = stage_data[NumPipeRegs].fmt;
  assign vectorial_o   = stage_data[NumPipeRegs].vectorial;
  assign lane_active_o = stage_data[NumPipeRegs].active;

  if (NumPipeRegs > 0) begin : gen_busy
    assign busy_o = |stage_valid[1:NumPipeRegs];
  end else begin : gen_no_busy
    assign busy_o = 1'b0;
  end

  // Encoding 3 has no format behind it
  fmt_legal_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    in_valid_i |-> (fmt_i < NUM_FP_FORMATS)
  );

endmodule

//--- verilog/result_assembler.sv
`timescale 1ns/1ps
/*
 * Combinational output stage of the slice.
 * Packs the lane results into one word for the item's format: element by
 * element for vectorial items, lane 0 with NaN-boxing above it for
 * scalar items. Also ORs the status of the lanes that count.
 */
module result_assembler import fp_simd_pkg::*; #(
  parameter int unsigned  Width     = 32,
  localparam int unsigned NUM_LANES = Width / LANE_BITS
) (
  input  logic [NUM_LANES-1:0][31:0] lane_results_i,
  input  status_t [NUM_LANES-1:0]    lane_status_i,
  input  fp_format_e                 fmt_i,
  input  logic                       vectorial_i,
  input  logic [NUM_LANES-1:0]       lane_active_i,
  output logic [Width-1:0]           result_o,
  output status_t                    status_o
);

  logic [NUM_FP_FORMATS-1:0][Width-1:0] vec_result;
  logic [NUM_FP_FORMATS-1:0][Width-1:0] scalar_result;

  // --------------------
  // Packing per format
  // --------------------
  for (genvar f = 0; f < NUM_FP_FORMATS; f++) begin : gen_pack
    localparam int unsigned FW = fp_width(fp_format_e'(f));

    logic [Width-1:0] boxed;

    // Element l sits at l times the format width
    for (genvar l = 0; l < Width / FW; l++) begin : gen_elem
      assign vec_result[f][l*FW +: FW] = lane_results_i[l][FW-1:0];
    end

    always_comb begin : box_scalar
      boxed         = '1;  // Everything above lane 0 reads as NaN
      boxed[FW-1:0] = lane_results_i[0][FW-1:0];
    end

    assign scalar_result[f] = boxed;
  end

  always_comb begin : select_result
    result_o = '1;
    if (fmt_i < NUM_FP_FORMATS) begin
      result_o = vectorial_i ? vec_result[fmt_i] : scalar_result[fmt_i];
    end
  end

  // --------------------
  // Status
  // --------------------
  always_comb begin : collapse_status
    logic [4:0] acc;

    acc = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      acc |= lane_status_i[l] & {5{lane_active_i[l]}};  // Masked lanes drop out
    end
    status_o = status_t'(acc);
  end

endmodule

//--- verilog/simd_noncomp_slice.sv
`timescale 1ns/1ps
/*
 * Top level of the SIMD non-computational FP slice.
 * Runs the lane datapath and the op info pipeline side by side and
 * joins them in the result assembler. Sign injection and MIN/MAX on
 * FP32, FP16 and FP8, scalar or vectorial, with a valid/ready handshake.
 */
module simd_noncomp_slice import fp_simd_pkg::*; #(
  parameter int unsigned  Width       = 32,
  parameter int unsigned  NumPipeRegs = 1,
  parameter type          TagType     = logic [7:0],
  localparam int unsigned NUM_LANES   = Width / LANE_BITS
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Input side
  input  logic [Width-1:0]     operand_a_i,
  input  logic [Width-1:0]     operand_b_i,
  input  fp_format_e           fmt_i,
  input  operation_e           op_i,
  input  logic                 vectorial_op_i,
  input  logic [NUM_LANES-1:0] simd_mask_i,
  input  TagType               tag_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic                 flush_i,
  // Output side
  output logic [Width-1:0]     result_o,
  output status_t              status_o,
  output TagType               tag_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic                 busy_o
);

  logic [NUM_LANES-1:0][31:0] lane_results;
  status_t [NUM_LANES-1:0]    lane_status;
  fp_format_e                 result_fmt;
  logic                       result_vectorial;
  logic [NUM_LANES-1:0]       lane_active;
  logic                       busy_data, busy_info;

  lane_datapath #(
    .Width       ( Width       ),
    .NumPipeRegs ( NumPipeRegs )
  ) u_lane_datapath (
    .clk_i, .rst_n_i, .flush_i, .in_valid_i, .in_ready_o,
    .operand_a_i, .operand_b_i, .fmt_i, .op_i, .out_valid_o, .out_ready_i,
    .busy_o         ( busy_data    ),
    .lane_results_o ( lane_results ),
    .lane_status_o  ( lane_status  )
  );

  op_info_pipe #(
    .Width       ( Width       ),
    .NumPipeRegs ( NumPipeRegs ),
    .TagType     ( TagType     )
  ) u_op_info_pipe (
    .clk_i, .rst_n_i, .flush_i, .in_valid_i, .out_ready_i,
    .fmt_i, .vectorial_op_i, .simd_mask_i, .tag_i, .tag_o,
    .busy_o        ( busy_info        ),
    .fmt_o         ( result_fmt       ),
    .vectorial_o   ( result_vectorial ),
    .lane_active_o ( lane_active      )
  );

  result_assembler #(
    .Width ( Width )
  ) u_result_assembler (
    .lane_results_i ( lane_results     ),
    .lane_status_i  ( lane_status      ),
    .fmt_i          ( result_fmt       ),
    .vectorial_i    ( result_vectorial ),
    .lane_active_i  ( lane_active      ),
    .result_o       ( result_o         ),
    .status_o       ( status_o         )
  );

  assign busy_o = busy_data | busy_info;

endmodule

//--- include/slice_tests.svh
/*
 * Directed tests and reference model for the SIMD non-computational slice.
 * Included inside the testbench module, so the tasks drive the DUT inputs
 * and read its outputs directly. Expected results go to a queue that the
 * testbench monitor checks in order.
 */
`ifndef SLICE_TESTS_SVH
`define SLICE_TESTS_SVH

typedef struct packed {
  logic [31:0] result;
  status_t     status;
  logic [7:0]  tag;
} expect_t;

expect_t expect_q[$];  // Items accepted and not yet seen at the output

// --------------------
// Reference model
// --------------------
function automatic int unsigned elem_width(fp_format_e fmt);
  case (fmt)
    FP16:    return 16;
    FP8:     return 8;
    default: return 32;
  endcase
endfunction

function automatic logic [31:0] man_mask(fp_format_e fmt);
  case (fmt)
    FP16:    return 32'h3ff;
    FP8:     return 32'h3;
    default: return 32'h7fffff;
  endcase
endfunction

// Unsigned key in the order of the real values, -0 just below +0
function automatic logic [31:0] order_key(logic [31:0] x, int unsigned w);
  logic [31:0] mask;
  logic [31:0] sign;
  mask = 32'((64'd1 << w) - 1);
  sign = 32'(1) << (w - 1);
  return ((x & sign) != 0) ? (~x & mask) : (x | sign);
endfunction

// One element, NV flag in the top bit
function automatic logic [32:0] ref_elem(logic [31:0] a, logic [31:0] b,
                                         fp_format_e fmt, operation_e op);
  int unsigned w;
  logic [31:0] mask, sign, mm, exp_ones, qbit, res;
  logic        nan_a, nan_b, snan_a, snan_b;
  w        = elem_width(fmt);
  mask     = 32'((64'd1 << w) - 1);
  sign     = 32'(1) << (w - 1);
  mm       = man_mask(fmt);
  exp_ones = mask & ~sign & ~mm;
  qbit     = (mm + 1) >> 1;  // Top mantissa bit
  a        = a & mask;
  b        = b & mask;
  nan_a    = ((a & exp_ones) == exp_ones) && ((a & mm) != 0);
  nan_b    = ((b & exp_ones) == exp_ones) && ((b & mm) != 0);
  snan_a   = nan_a && ((a & qbit) == 0);
  snan_b   = nan_b && ((b & qbit) == 0);
  res      = a;
  case (op)
    SGNJ:  res = (a & ~sign) | (b & sign);
    SGNJN: res = (a & ~sign) | (~b & sign);
    SGNJX: res = a ^ (b & sign);
    default: begin
      if (nan_a && nan_b) res = exp_ones | qbit;  // Canonical NaN
      else if (nan_a) res = b;
      else if (nan_b) res = a;
      else if ((order_key(a, w) < order_key(b, w)) != (op == MIN)) res = b;
      return {snan_a | snan_b, res};
    end
  endcase
  return {1'b0, res};
endfunction

function automatic expect_t ref_word(logic [31:0] a, logic [31:0] b, fp_format_e fmt,
                                     operation_e op, logic vec, logic [3:0] simd,
                                     logic [7:0] tag);
  int unsigned w;
  int unsigned n;
  logic [31:0] emask;
  logic [32:0] e;
  expect_t     x;
  w        = elem_width(fmt);
  n        = vec ? 32 / w : 1;  // Scalar items use lane 0 only
  emask    = 32'((64'd1 << w) - 1);
  x.result = '1;                // NaN-boxed above the last element
  x.status = '0;
  x.tag    = tag;
  for (int unsigned l = 0; l < n; l++) begin
    e           = ref_elem(a >> (l * w), b >> (l * w), fmt, op);
    x.result    = (x.result & ~(emask << (l * w))) | ((e[31:0] & emask) << (l * w));
    x.status.NV = x.status.NV | (e[32] & simd[l]);  // Mask gates status only
  end
  return x;
endfunction

// Random word with some elements swapped for zeros, infinities and NaNs
function automatic logic [31:0] mixed_operand(fp_format_e fmt);
  int unsigned w;
  logic [31:0] emask, sign, exp_ones, elem, word;
  w        = elem_width(fmt);
  emask    = 32'((64'd1 << w) - 1);
  sign     = 32'(1) << (w - 1);
  exp_ones = emask & ~sign & ~man_mask(fmt);
  word     = $random(seed);
  for (int unsigned l = 0; l < 32 / w; l++) begin
    elem = (word >> (l * w)) & emask;
    case ($unsigned($random(seed)) % 8)
      0: elem = '0;
      1: elem = sign;        // -0
      2: elem = exp_ones;    // +inf
      3: elem = sign | exp_ones;
      4: elem = exp_ones | ((man_mask(fmt) + 1) >> 1);  // Quiet NaN
      5: elem = exp_ones | 32'd1;                         // Signaling NaN
      default: ;
    endcase
    word = (word & ~(emask << (l * w))) | (elem << (l * w));
  end
  return word;
endfunction

// --------------------
// Driver and reporting
// --------------------
task automatic value_error(string name, logic [31:0] got, logic [31:0] want);
  $display("** Error: %s = 0x%h, expected 0x%h", name, got, want);
  errors++;
endtask

// Drive one item at the current edge and hold it until the DUT takes it
task automatic push_item(logic [31:0] a, logic [31:0] b, fp_format_e fmt,
                         operation_e op, logic vec, logic [3:0] simd);
  expect_q.push_back(ref_word(a, b, fmt, op, vec, simd, tag_cnt));
  in_valid_i     <= 1'b1;
  operand_a_i    <= a;
  operand_b_i    <= b;
  fmt_i          <= fmt;
  op_i           <= op;
  vectorial_op_i <= vec;
  simd_mask_i    <= simd;
  tag_i          <= tag_cnt;
  tag_cnt++;
  do @(posedge clk_i); while (!in_ready_o);
endtask

task automatic drain();
  in_valid_i <= 1'b0;
  while (expect_q.size() != 0) @(posedge clk_i);
  @(posedge clk_i);
endtask

task automatic end_test(string name, int errors_before);
  tests_run++;
  if (errors == errors_before) $display("%s: ok", name);
  else $display("%s: %0d errors", name, errors - errors_before);
endtask

task automatic check_output(expect_t exp);
  checks += 3;
  assert (result_o === exp.result) else value_error("result_o", result_o, exp.result);
  assert (status_o === exp.status)
    else value_error("status_o", 32'(status_o), 32'(exp.status));
  assert (tag_o === exp.tag) else value_error("tag_o", 32'(tag_o), 32'(exp.tag));
endtask

// --------------------
// Tests
// --------------------
task automatic test_reset();
  int e0;
  e0 = errors;
  @(posedge clk_i);
  checks += 3;
  assert (out_valid_o === 1'b0) else value_error("out_valid_o", 32'(out_valid_o), 0);
  assert (busy_o === 1'b0) else value_error("busy_o", 32'(busy_o), 0);
  assert (in_ready_o === 1'b1) else value_error("in_ready_o", 32'(in_ready_o), 1);
  end_test("reset state", e0);
endtask

task automatic test_sign_inject();
  int          e0;
  logic [31:0] a, b;
  e0 = errors;
  for (int f = 0; f < 2; f++) begin      // FP32 then FP16
    for (int o = 0; o < 3; o++) begin    // SGNJ, SGNJN, SGNJX
      for (int k = 0; k < 4; k++) begin
        a = $random(seed);
        b = $random(seed);
        push_item(a, b, fp_format_e'(f), operation_e'(o), 1'b0, 4'hf);
      end
    end
  end
  drain();
  end_test("scalar sign injection", e0);
endtask

task automatic test_minmax();
  int          e0;
  fp_format_e  fmt;
  logic [31:0] a, b;
  e0 = errors;
  for (int f = 0; f < 2; f++) begin
    fmt = (f == 0) ? FP8 : FP16;
    for (int k = 0; k < 16; k++) begin
      a = mixed_operand(fmt);
      b = mixed_operand(fmt);
      push_item(a, b, fmt, (k % 2 == 0) ? MIN : MAX, 1'b1, 4'hf);
    end
  end
  drain();
  end_test("vectorial min/max", e0);
endtask

// One signaling FP8 lane against 1.0 and 2.0, over every mask value
task automatic test_mask();
  int          e0;
  logic [31:0] a;
  e0 = errors;
  for (int l = 0; l < 4; l++) begin
    a = (32'h3c3c3c3c & ~(32'hff << (8 * l))) | (32'h7d << (8 * l));
    for (int m = 0; m < 16; m++) begin
      push_item(a, 32'h40404040, FP8, MIN, 1'b1, 4'(m));
    end
  end
  drain();
  end_test("simd mask", e0);
endtask

task automatic test_backpressure();
  int          e0;
  logic [31:0] a_vals[20];
  logic [31:0] b_vals[20];
  logic [31:0] rnd;
  bit          streaming;
  e0 = errors;
  for (int i = 0; i < 20; i++) begin
    a_vals[i] = mixed_operand(FP16);
    b_vals[i] = mixed_operand(FP16);
  end
  streaming = 1'b1;
  fork
    begin
      for (int i = 0; i < 20; i++) begin
        push_item(a_vals[i], b_vals[i], FP16, (i % 2 == 0) ? MAX : MIN, 1'b1, 4'hf);
      end
      drain();
      streaming = 1'b0;
    end
    while (streaming) begin
      rnd = $random(seed);
      out_ready_i <= rnd[0];  // Consumer stalls about half the time
      @(posedge clk_i);
    end
  join
  out_ready_i <= 1'b1;
  end_test("back-pressure", e0);
endtask

task automatic test_flush();
  int e0;
  e0 = errors;
  out_ready_i <= 1'b0;  // Hold both items inside the pipeline
  push_item(32'h3c003c00, 32'hbc00c000, FP16, MAX, 1'b1, 4'hf);
  push_item(32'h7e007e00, 32'h00000000, FP16, MIN, 1'b1, 4'hf);
  in_valid_i <= 1'b0;
  flush_i    <= 1'b1;
  expect_q.delete();
  @(posedge clk_i);
  flush_i     <= 1'b0;
  out_ready_i <= 1'b1;
  @(posedge clk_i);
  checks += 2;
  assert (busy_o === 1'b0) else value_error("busy_o", 32'(busy_o), 0);
  assert (out_valid_o === 1'b0) else value_error("out_valid_o", 32'(out_valid_o), 0);
  repeat (4) @(posedge clk_i);
  push_item(32'h12345678, 32'h80000000, FP32, SGNJN, 1'b0, 4'hf);
  drain();
  end_test("flush", e0);
endtask

`endif

//--- test/tb_simd_noncomp_slice.sv
`timescale 1ns/1ps
/*
 * Testbench for the SIMD non-computational slice, Width 32 with two
 * pipeline stages. Runs the directed tests from slice_tests.svh, checks
 * every output item in order against the reference model and ends with
 * a summary line.
 */
module tb_simd_noncomp_slice import fp_simd_pkg::*; ();

  localparam int unsigned ITEMS           = 150;  // Bound on items over all tests
  localparam int unsigned CYCLES_PER_ITEM = 20;   // Stalls and drains included
  localparam int unsigned TIMEOUT_CYCLES  = ITEMS * CYCLES_PER_ITEM;

  logic        clk_i;
  logic        rst_n_i;
  logic [31:0] operand_a_i, operand_b_i;
  fp_format_e  fmt_i;
  operation_e  op_i;
  logic        vectorial_op_i;
  logic [3:0]  simd_mask_i;
  logic [7:0]  tag_i;
  logic        in_valid_i, in_ready_o, flush_i;
  logic [31:0] result_o;
  status_t     status_o;
  logic [7:0]  tag_o;
  logic        out_valid_o, out_ready_i, busy_o;

  // Bookkeeping
  integer      seed;
  int          errors    = 0;
  int          checks    = 0;
  int          tests_run = 0;
  int unsigned cycles    = 0;
  logic [7:0]  tag_cnt   = 8'h00;
  logic        stalled   = 1'b0;
  logic [31:0] held_result;
  status_t     held_status;
  logic [7:0]  held_tag;

  simd_noncomp_slice #(
    .Width       ( 32          ),
    .NumPipeRegs ( 2           ),
    .TagType     ( logic [7:0] )
  ) simd_noncomp_slice_inst (.*);

  `include "slice_tests.svh"

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // --------------------
  // Output monitor
  // --------------------
  always @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      stalled = 1'b0;
    end else begin
      if (stalled) begin
        checks++;
        assert (out_valid_o && result_o === held_result && status_o === held_status
                && tag_o === held_tag)
          else begin
            $display("Output changed or dropped while stalled by out_ready_i");
            errors++;
          end
      end
      if (out_valid_o && out_ready_i) begin
        checks++;
        assert (expect_q.size() != 0)
          else begin
            $display("Output item appeared with no accepted item outstanding");
            errors++;
          end
        if (expect_q.size() != 0) begin
          check_output(expect_q.pop_front());
        end
      end
      stalled     = out_valid_o && !out_ready_i;
      held_result = result_o;
      held_status = status_o;
      held_tag    = tag_o;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycles);
      $display("test failed");
      $finish;
    end
  end

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    seed           = 32'haea5;
    rst_n_i        = 1'b0;
    operand_a_i    = '0;
    operand_b_i    = '0;
    fmt_i          = FP32;
    op_i           = SGNJ;
    vectorial_op_i = 1'b0;
    simd_mask_i    = '0;
    tag_i          = '0;
    in_valid_i     = 1'b0;
    flush_i        = 1'b0;
    out_ready_i    = 1'b1;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;

    test_reset();
    test_sign_inject();
    test_minmax();
    test_mask();
    test_backpressure();
    test_flush();

    $display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- simd_noncomp_slice.f
+incdir+include
verilog/fp_simd_pkg.sv
verilog/pipe_stage.sv
verilog/noncomp_lane.sv
verilog/lane_datapath.sv
verilog/op_info_pipe.sv
verilog/result_assembler.sv
verilog/simd_noncomp_slice.sv
test/tb_simd_noncomp_slice.sv

//--- Makefile
# Verilator build and run of the SIMD non-computational slice testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_simd_noncomp_slice
FILELIST  := simd_noncomp_slice.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)

SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := $(wildcard include/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# Passes only when the run prints the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'test passed'

clean:
	rm -rf $(OBJDIR)
